// ==== sources.f ====
src/riscv_pkg.sv
src/register_file.sv
src/riscv_if.sv
src/riscv_id.sv
src/riscv_ex.sv
src/riscv_mem.sv
src/hazard_unit.sv
src/riscv_pipeline.sv
tests/clock_gen.sv
tests/riscv_pipeline_properties.sv
tests/riscv_pipeline_tb.sv

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import riscv_pkg::*; (
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    input  wire logic     is_branch,
    input  wire logic     branch_taken,
    input  wire logic     jump_taken,
    input  wire id_ex_t   id_ex,
    input  wire ex_mem_t  ex_mem,
    input  wire logic     icache_stall,
    input  wire logic     dcache_stall,
    output logic          freeze,
    output logic          hold_front,
    output logic          flush_if_id,
    output logic          flush_id_ex
);

    logic id_ex_writes;
    logic ex_mem_writes;
    logic id_ex_match;
    logic ex_mem_match;
    logic load_use;
    logic branch_dep;

    assign id_ex_writes  = id_ex.valid && id_ex.reg_wen && id_ex.rd != '0;
    assign ex_mem_writes = ex_mem.valid && ex_mem.reg_wen && ex_mem.rd != '0;
    assign id_ex_match   = (id_ex.rd == rs1) || (id_ex.rd == rs2);
    assign ex_mem_match  = (ex_mem.rd == rs1) || (ex_mem.rd == rs2);

    // loaded value only exists after MEM
    assign load_use = id_ex_writes && id_ex.mem_ren && id_ex_match;

    // branch compares in decode, so wait for producers still in EX or MEM
    assign branch_dep = is_branch && ((id_ex_writes && id_ex_match) ||
                                      (ex_mem_writes && ex_mem_match));

    assign freeze      = icache_stall || dcache_stall;
    assign hold_front  = load_use || branch_dep;
    assign flush_if_id = jump_taken || (branch_taken && !hold_front);
    assign flush_id_ex = jump_taken;

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import riscv_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    input  wire wb_t      wb,
    output word_t         rs1_data,
    output word_t         rs2_data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write passes straight through to decode
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else if (wb.wen && wb.rd == rs1) begin
            rs1_data = wb.data;
        end else begin
            rs1_data = regs[rs1];
        end
        if (rs2 == '0) begin
            rs2_data = '0;
        end else if (wb.wen && wb.rd == rs2) begin
            rs2_data = wb.data;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

`default_nettype wire

// ==== src/riscv_ex.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_ex import riscv_pkg::*; (
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   freeze,
    input  wire id_ex_t id_ex,
    input  wire wb_t    wb,
    output logic        jump_taken,
    output addr_t       jump_target,
    output ex_mem_t     ex_mem
);

    word_t ex_mem_value;
    word_t op_a;
    word_t fwd_b;
    word_t op_b;
    word_t alu_result;

    // a jump in EX/MEM writes its link value, not the ALU result
    assign ex_mem_value = ex_mem.jump ? ex_mem.pc_plus_4 : ex_mem.alu_result;

    always_comb begin
        if (id_ex.rs1 != '0 && ex_mem.valid && ex_mem.reg_wen && ex_mem.rd == id_ex.rs1) begin
            op_a = ex_mem_value;
        end else if (id_ex.rs1 != '0 && wb.wen && wb.rd == id_ex.rs1) begin
            op_a = wb.data;
        end else begin
            op_a = id_ex.rs1_data;
        end
        if (id_ex.rs2 != '0 && ex_mem.valid && ex_mem.reg_wen && ex_mem.rd == id_ex.rs2) begin
            fwd_b = ex_mem_value;
        end else if (id_ex.rs2 != '0 && wb.wen && wb.rd == id_ex.rs2) begin
            fwd_b = wb.data;
        end else begin
            fwd_b = id_ex.rs2_data;
        end
    end

    assign op_b = id_ex.alu_src ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.alu_op)
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    assign jump_taken  = id_ex.valid && (id_ex.jal || id_ex.jalr);
    assign jump_target = id_ex.jal ? id_ex.pc + id_ex.imm
                                   : (op_a + id_ex.imm) & ~32'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (!freeze) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= fwd_b;
            ex_mem.pc_plus_4  <= id_ex.pc + 32'd4;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_ren    <= id_ex.mem_ren;
            ex_mem.mem_wen    <= id_ex.mem_wen;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
            ex_mem.reg_wen    <= id_ex.reg_wen;
            ex_mem.jump       <= id_ex.jal || id_ex.jalr;
        end
    end

endmodule

`default_nettype wire

// ==== src/riscv_id.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_id import riscv_pkg::*; (
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   freeze,
    input  wire logic   hold_front,
    input  wire logic   flush_id_ex,
    input  wire if_id_t if_id,
    input  wire word_t  rs1_data,
    input  wire word_t  rs2_data,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output logic        is_branch,
    output logic        branch_taken,
    output addr_t       branch_target,
    output id_ex_t      id_ex
);

    opcode_e  opcode;
    logic [2:0] funct3;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_b;
    word_t    imm_j;
    word_t    imm_u;
    logic     branch_op;
    logic     operands_equal;
    id_ex_t   id_ex_d;

    assign opcode = opcode_e'(if_id.inst[6:0]);
    assign funct3 = if_id.inst[14:12];
    assign rs1    = if_id.inst[19:15];
    assign rs2    = if_id.inst[24:20];

    // immediate formats
    assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
    assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                    if_id.inst[30:25], if_id.inst[11:8], 1'b0};
    assign imm_j = {{11{if_id.inst[31]}}, if_id.inst[31], if_id.inst[19:12],
                    if_id.inst[20], if_id.inst[30:21], 1'b0};
    assign imm_u = {if_id.inst[31:12], 12'b0};

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = if_id.valid;
        id_ex_d.pc       = if_id.pc;
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rd       = if_id.inst[11:7];
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm_i;
        id_ex_d.alu_op   = alu_add;
        branch_op        = 1'b0;
        case (opcode)
            opc_reg: begin
                id_ex_d.reg_wen = 1'b1;
                case (funct3)
                    3'b000:  id_ex_d.alu_op = if_id.inst[30] ? alu_sub : alu_add;
                    3'b111:  id_ex_d.alu_op = alu_and;
                    3'b110:  id_ex_d.alu_op = alu_or;
                    3'b100:  id_ex_d.alu_op = alu_xor;
                    3'b010:  id_ex_d.alu_op = alu_slt;
                    default: id_ex_d.alu_op = alu_add;
                endcase
            end
            opc_imm: begin
                id_ex_d.reg_wen = 1'b1;
                id_ex_d.alu_src = 1'b1;
            end
            opc_load: begin
                id_ex_d.mem_ren    = 1'b1;
                id_ex_d.mem_to_reg = 1'b1;
                id_ex_d.reg_wen    = 1'b1;
                id_ex_d.alu_src    = 1'b1;
            end
            opc_store: begin
                id_ex_d.mem_wen = 1'b1;
                id_ex_d.alu_src = 1'b1;
                id_ex_d.imm     = imm_s;
            end
            opc_branch: begin
                branch_op   = 1'b1;
                id_ex_d.imm = imm_b;
            end
            opc_jal: begin
                id_ex_d.jal     = 1'b1;
                id_ex_d.reg_wen = 1'b1;
                id_ex_d.imm     = imm_j;
            end
            opc_jalr: begin
                id_ex_d.jalr    = 1'b1;
                id_ex_d.reg_wen = 1'b1;
            end
            opc_lui: begin
                id_ex_d.reg_wen = 1'b1;
                id_ex_d.alu_src = 1'b1;
                id_ex_d.imm     = imm_u;
                id_ex_d.alu_op  = alu_pass_b;
            end
            default: ;
        endcase
    end

    // beq when funct3[0] is clear, bne when set
    assign operands_equal = (rs1_data == rs2_data);
    assign is_branch      = if_id.valid && branch_op;
    assign branch_taken   = is_branch && !hold_front && (operands_equal ^ funct3[0]);
    assign branch_target  = if_id.pc + imm_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (!freeze) begin
            if (flush_id_ex || hold_front) begin
                id_ex <= '0;
            end else begin
                id_ex <= id_ex_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/riscv_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_if import riscv_pkg::*; (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  freeze,
    input  wire logic  hold_front,
    input  wire logic  flush_if_id,
    input  wire logic  branch_taken,
    input  wire addr_t branch_target,
    input  wire logic  jump_taken,
    input  wire addr_t jump_target,
    input  wire logic  icache_stall,
    input  wire inst_t icache_rdata,
    output logic       icache_ren,
    output waddr_t     icache_addr,
    output if_id_t     if_id
);

    addr_t pc;
    addr_t pc_next;
    logic  advance;

    // instruction word only counts once the stall drops
    assign advance     = !freeze && !icache_stall;
    assign icache_addr = pc[31:2];

    // jump from execute is older than a branch in decode
    always_comb begin
        if (jump_taken) begin
            pc_next = jump_target;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            icache_ren <= 1'b0;
            pc         <= reset_pc;
            if_id      <= '{valid: 1'b0, pc: reset_pc, inst: nop_inst};
        end else begin
            // fetching starts on the first edge out of reset
            icache_ren <= 1'b1;
            if (advance && icache_ren && (jump_taken || !hold_front)) begin
                pc <= pc_next;
            end
            if (advance) begin
                if (flush_if_id) begin
                    if_id <= '{valid: 1'b0, pc: if_id.pc, inst: nop_inst};
                end else if (!hold_front) begin
                    if_id <= '{valid: icache_ren, pc: pc, inst: icache_rdata};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/riscv_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_mem import riscv_pkg::*; (
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    freeze,
    input  wire ex_mem_t ex_mem,
    input  wire logic    dcache_stall,
    input  wire word_t   dcache_rdata,
    output logic         dcache_ren,
    output logic         dcache_wen,
    output waddr_t       dcache_addr,
    output word_t        dcache_wdata,
    output mem_wb_t      mem_wb
);

    logic advance;

    // request held as long as EX/MEM is held
    assign dcache_ren   = ex_mem.valid && ex_mem.mem_ren;
    assign dcache_wen   = ex_mem.valid && ex_mem.mem_wen;
    assign dcache_addr  = ex_mem.alu_result[31:2];
    assign dcache_wdata = ex_mem.store_data;

    // read data is only good once the stall drops
    assign advance = !freeze && !dcache_stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else if (advance) begin
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.mem_data   <= dcache_rdata;
            mem_wb.pc_plus_4  <= ex_mem.pc_plus_4;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
            mem_wb.reg_wen    <= ex_mem.valid && ex_mem.reg_wen;
            mem_wb.jump       <= ex_mem.jump;
        end
    end

endmodule

`default_nettype wire

// ==== src/riscv_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline import riscv_pkg::*; (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  icache_stall,
    output logic       icache_ren,
    output waddr_t     icache_addr,
    input  wire inst_t icache_rdata,
    input  wire logic  dcache_stall,
    output logic       dcache_ren,
    output logic       dcache_wen,
    output waddr_t     dcache_addr,
    input  wire word_t dcache_rdata,
    output word_t      dcache_wdata
);

    logic     freeze;
    logic     hold_front;
    logic     flush_if_id;
    logic     flush_id_ex;
    logic     branch_taken;
    addr_t    branch_target;
    logic     jump_taken;
    addr_t    jump_target;
    logic     is_branch;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    wb_t      wb;

    riscv_if if_i (
        .clk, .arst_n, .freeze, .hold_front, .flush_if_id,
        .branch_taken, .branch_target, .jump_taken, .jump_target,
        .icache_stall, .icache_rdata, .icache_ren, .icache_addr, .if_id
    );

    riscv_id id_i (
        .clk, .arst_n, .freeze, .hold_front, .flush_id_ex, .if_id,
        .rs1_data, .rs2_data, .rs1, .rs2, .is_branch,
        .branch_taken, .branch_target, .id_ex
    );

    register_file regfile_i (
        .clk, .arst_n, .rs1, .rs2, .wb, .rs1_data, .rs2_data
    );

    riscv_ex ex_i (
        .clk, .arst_n, .freeze, .id_ex, .wb, .jump_taken, .jump_target, .ex_mem
    );

    riscv_mem mem_i (
        .clk, .arst_n, .freeze, .ex_mem, .dcache_stall, .dcache_rdata,
        .dcache_ren, .dcache_wen, .dcache_addr, .dcache_wdata, .mem_wb
    );

    hazard_unit hazard_i (
        .rs1, .rs2, .is_branch, .branch_taken, .jump_taken, .id_ex, .ex_mem,
        .icache_stall, .dcache_stall, .freeze, .hold_front, .flush_if_id, .flush_id_ex
    );

    // write-back mux, no register write while the pipeline is frozen
    always_comb begin
        wb.wen = mem_wb.reg_wen && !freeze;
        wb.rd  = mem_wb.rd;
        if (mem_wb.mem_to_reg) begin
            wb.data = mem_wb.mem_data;
        end else if (mem_wb.jump) begin
            wb.data = mem_wb.pc_plus_4;
        end else begin
            wb.data = mem_wb.alu_result;
        end
    end

endmodule

`default_nettype wire

// ==== src/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [29:0] waddr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_reg    = 7'b0110011,
        opc_imm    = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        logic     alu_src;
        alu_op_e  alu_op;
        logic     jal;
        logic     jalr;
        logic     mem_ren;
        logic     mem_wen;
        logic     mem_to_reg;
        logic     reg_wen;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        addr_t    pc_plus_4;
        reg_idx_t rd;
        logic     mem_ren;
        logic     mem_wen;
        logic     mem_to_reg;
        logic     reg_wen;
        logic     jump;
    } ex_mem_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    mem_data;
        addr_t    pc_plus_4;
        reg_idx_t rd;
        logic     mem_to_reg;
        logic     reg_wen;
        logic     jump;
    } mem_wb_t;

    // write-back loop toward register file and forwarding
    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    localparam addr_t reset_pc = 32'h0000_0000;
    // addi x0, x0, 0
    localparam inst_t nop_inst = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic arst_n
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/riscv_pipeline_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline_properties import riscv_pkg::*; (
    input wire logic   clk,
    input wire logic   arst_n,
    input wire logic   icache_stall,
    input wire logic   icache_ren,
    input wire waddr_t icache_addr,
    input wire logic   dcache_stall,
    input wire logic   dcache_ren,
    input wire logic   dcache_wen,
    input wire waddr_t dcache_addr,
    input wire word_t  dcache_wdata
);

    // one data access at a time
    assert property (@(posedge clk) disable iff (!arst_n) !(dcache_ren && dcache_wen))
        else $error("dcache read and write strobes high together");

    assert property (@(posedge clk) disable iff (!arst_n)
        dcache_stall |=> $stable(dcache_addr) && $stable(dcache_wdata) &&
                         $stable(dcache_ren) && $stable(dcache_wen))
        else $error("dcache request changed while stalled");

    assert property (@(posedge clk) disable iff (!arst_n) icache_stall |=> $stable(icache_addr))
        else $error("icache address changed while stalled");

    // no fetch while reset is held
    assert property (@(posedge clk) !arst_n |-> !icache_ren)
        else $error("icache read strobe high during reset");

endmodule

bind riscv_pipeline riscv_pipeline_properties props_i (.*);

`default_nettype wire

// ==== tests/riscv_pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline_tb import riscv_pkg::*; ();

    localparam int num_tests = 6;
    localparam int prog_words = 24;
    localparam int max_stores = 8;

    logic   clk;
    logic   gen_rst_n;
    logic   test_rst_n;
    logic   arst_n;
    logic   icache_stall;
    logic   icache_ren;
    waddr_t icache_addr;
    inst_t  icache_rdata;
    logic   dcache_stall;
    logic   dcache_ren;
    logic   dcache_wen;
    waddr_t dcache_addr;
    word_t  dcache_rdata;
    word_t  dcache_wdata;

    // test table
    string  test_name [num_tests];
    inst_t  prog [num_tests][prog_words];
    int     num_stores [num_tests];
    waddr_t exp_addr [num_tests][max_stores];
    word_t  exp_data [num_tests][max_stores];
    logic   use_stalls [num_tests];

    inst_t  imem [0:63];
    word_t  dmem [0:63];
    waddr_t seen_addr [$];
    word_t  seen_data [$];
    logic   stall_en;
    integer seed;
    int     errors;
    int     passed;
    int     failed;

    clock_gen clock_gen_i (.clk(clk), .arst_n(gen_rst_n));

    assign arst_n = gen_rst_n && test_rst_n;

    riscv_pipeline dut_i (
        .clk, .arst_n, .icache_stall, .icache_ren, .icache_addr, .icache_rdata,
        .dcache_stall, .dcache_ren, .dcache_wen, .dcache_addr, .dcache_rdata, .dcache_wdata
    );

    // caches answer in the same cycle as the request
    assign icache_rdata = (icache_addr < 64) ? imem[icache_addr[5:0]] : nop_inst;
    assign dcache_rdata = (dcache_ren && dcache_addr < 64) ? dmem[dcache_addr[5:0]]
                                                           : 32'hbad0_bad0;

    always @(posedge clk) begin
        icache_stall <= stall_en && (($random(seed) & 3) == 0);
        dcache_stall <= stall_en && (($random(seed) & 3) == 0);
    end

    // a store completes on an edge where the pipeline advances
    always @(posedge clk) begin
        if (arst_n && dcache_wen && !dcache_stall && !icache_stall) begin
            dmem[dcache_addr[5:0]] <= dcache_wdata;
            seen_addr.push_back(dcache_addr);
            seen_data.push_back(dcache_wdata);
        end
    end

    function automatic inst_t enc_r(input logic [6:0] f7, input int rd, input int rs1,
                                    input int rs2, input logic [2:0] f3);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic inst_t enc_i(input logic [6:0] op, input int rd, input int rs1,
                                    input int imm);
        logic [31:0] i;
        i = imm;
        return {i[11:0], 5'(rs1), (op == 7'b0000011) ? 3'b010 : 3'b000, 5'(rd), op};
    endfunction

    function automatic inst_t enc_sw(input int rs2, input int rs1, input int imm);
        logic [31:0] i;
        i = imm;
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic inst_t enc_br(input logic [2:0] f3, input int rs1, input int rs2,
                                     input int imm);
        logic [31:0] i;
        i = imm;
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic inst_t enc_jal(input int rd, input int imm);
        logic [31:0] i;
        i = imm;
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic inst_t enc_lui(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    function automatic inst_t addi(input int rd, input int rs1, input int imm);
        return enc_i(7'b0010011, rd, rs1, imm);
    endfunction

    task automatic add_store(input int t, input waddr_t a, input word_t d);
        exp_addr[t][num_stores[t]] = a;
        exp_data[t][num_stores[t]] = d;
        num_stores[t]++;
    endtask

    task automatic build_table();
        for (int t = 0; t < num_tests; t++) begin
            num_stores[t] = 0;
            use_stalls[t] = 1'b0;
            for (int w = 0; w < prog_words; w++) begin
                prog[t][w] = nop_inst;
            end
        end
        // dependent ALU chain
        test_name[0] = "alu_chain";
        prog[0][0] = addi(1, 0, 5);
        prog[0][1] = addi(2, 1, 7);
        prog[0][2] = enc_r(7'h00, 3, 1, 2, 3'b000);
        prog[0][3] = enc_r(7'h20, 4, 3, 1, 3'b000);
        prog[0][4] = enc_r(7'h00, 5, 4, 3, 3'b110);
        prog[0][5] = enc_r(7'h00, 6, 5, 2, 3'b111);
        prog[0][6] = enc_r(7'h00, 7, 6, 3, 3'b100);
        prog[0][7] = enc_r(7'h20, 9, 1, 2, 3'b000);
        prog[0][8] = enc_r(7'h00, 10, 9, 1, 3'b010);
        prog[0][9] = enc_lui(11, 20'h12345);
        prog[0][10] = addi(11, 11, 12'h678);
        prog[0][11] = enc_sw(3, 0, 0);
        prog[0][12] = enc_sw(5, 0, 4);
        prog[0][13] = enc_sw(6, 0, 8);
        prog[0][14] = enc_sw(7, 0, 12);
        prog[0][15] = enc_sw(9, 0, 16);
        prog[0][16] = enc_sw(10, 0, 20);
        prog[0][17] = enc_sw(11, 0, 24);
        prog[0][18] = enc_jal(0, 0);
        add_store(0, 0, 17);
        add_store(0, 1, 29);
        add_store(0, 2, 12);
        add_store(0, 3, 29);
        add_store(0, 4, 32'hffff_fff9);
        add_store(0, 5, 1);
        add_store(0, 6, 32'h1234_5678);
        // load followed at once by its use
        test_name[1] = "load_use";
        prog[1][0] = addi(1, 0, 42);
        prog[1][1] = enc_sw(1, 0, 64);
        prog[1][2] = enc_i(7'b0000011, 2, 0, 64);
        prog[1][3] = enc_r(7'h00, 3, 2, 1, 3'b000);
        prog[1][4] = enc_sw(3, 0, 68);
        prog[1][5] = enc_jal(0, 0);
        add_store(1, 16, 42);
        add_store(1, 17, 84);
        test_name[2] = "branches";
        prog[2][0] = addi(1, 0, 3);
        prog[2][1] = addi(2, 0, 3);
        prog[2][2] = enc_br(3'b000, 1, 2, 8);
        prog[2][3] = enc_sw(1, 0, 0);
        prog[2][4] = enc_sw(2, 0, 4);
        prog[2][5] = addi(3, 0, 1);
        prog[2][6] = enc_br(3'b001, 1, 2, 8);
        prog[2][7] = enc_sw(3, 0, 8);
        prog[2][8] = enc_br(3'b001, 1, 3, 8);
        prog[2][9] = enc_sw(1, 0, 12);
        prog[2][10] = enc_br(3'b000, 1, 3, 8);
        prog[2][11] = enc_sw(1, 0, 16);
        prog[2][12] = enc_jal(0, 0);
        add_store(2, 1, 3);
        add_store(2, 2, 1);
        add_store(2, 4, 3);
        test_name[3] = "jumps";
        prog[3][0] = enc_jal(1, 12);
        prog[3][1] = enc_sw(1, 0, 0);
        prog[3][2] = enc_sw(1, 0, 4);
        prog[3][3] = enc_sw(1, 0, 8);
        prog[3][4] = addi(5, 0, 36);
        prog[3][5] = enc_i(7'b1100111, 6, 5, 0);
        prog[3][6] = enc_sw(5, 0, 12);
        prog[3][7] = enc_sw(5, 0, 16);
        prog[3][8] = enc_sw(5, 0, 20);
        prog[3][9] = enc_sw(6, 0, 24);
        prog[3][10] = enc_jal(0, 0);
        add_store(3, 2, 4);
        add_store(3, 6, 24);
        // same program as the ALU chain, random stalls on both ports
        test_name[4] = "alu_chain_stalls";
        prog[4] = prog[0];
        num_stores[4] = num_stores[0];
        exp_addr[4] = exp_addr[0];
        exp_data[4] = exp_data[0];
        use_stalls[4] = 1'b1;
        test_name[5] = "x0_write";
        prog[5][0] = addi(0, 0, 7);
        prog[5][1] = enc_sw(0, 0, 0);
        prog[5][2] = enc_r(7'h00, 1, 0, 0, 3'b000);
        prog[5][3] = enc_sw(1, 0, 4);
        prog[5][4] = enc_jal(0, 0);
        add_store(5, 0, 32'h0);
        add_store(5, 1, 32'h0);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERROR %s: store data expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input waddr_t exp, input waddr_t act);
        if (exp !== act) begin
            $display("ERROR %s: store address expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int cycles;
        int errors_before;
        int n;
        errors_before = errors;
        n = num_stores[t];
        @(posedge clk);
        test_rst_n <= 1'b0;
        stall_en   <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog_words) ? prog[t][i] : nop_inst;
            dmem[i] = 32'hdead_0000 ^ (i * 32'h0001_0101);
        end
        seen_addr.delete();
        seen_data.delete();
        repeat (5) @(posedge clk);
        test_rst_n <= 1'b1;
        stall_en   <= use_stalls[t];
        cycles = 0;
        while (seen_addr.size() < n && cycles < 500) begin
            @(posedge clk);
            cycles++;
        end
        if (seen_addr.size() < n) begin
            $display("%s: timed out after 500 cycles with %0d of %0d stores",
                     test_name[t], seen_addr.size(), n);
            errors++;
        end else begin
            // any later store is off the architectural path
            repeat (20) @(posedge clk);
            for (int i = 0; i < n; i++) begin
                check_addr(test_name[t], exp_addr[t][i], seen_addr[i]);
                check_word(test_name[t], exp_data[t][i], seen_data[i]);
            end
            if (seen_addr.size() > n) begin
                $display("%s: %0d unexpected extra stores", test_name[t], seen_addr.size() - n);
                errors++;
            end
        end
        if (errors == errors_before) begin
            $display("PASS %s", test_name[t]);
            passed++;
        end else begin
            $display("FAIL %s", test_name[t]);
            failed++;
        end
    endtask

    initial begin
        seed         = 32'hbae2_654a;
        test_rst_n   = 1'b0;
        stall_en     = 1'b0;
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
